// File: core.f
+incdir+bench
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/inst_if.sv
verilog/fetch_decode.sv
verilog/inst_queue.sv
verilog/execute.sv
verilog/core.sv
bench/core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench
TOP = core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f core.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "test passed" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: bench/core_ref.svh
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

//////////////////////
// Instruction encoders
//////////////////////
function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
	return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
		input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, opc};
endfunction

// SW only, split immediate
function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
endfunction

function automatic word_t u_type(input logic [6:0] opc, input reg_addr_t rd,
		input logic [19:0] imm);
	return {imm, rd, opc};
endfunction

function automatic word_t ecall();
	return i_type(SYSTEM, 3'b000, 5'd0, 5'd0, 12'd0);	// Halt
endfunction

// Byte offset of a word inside the test region
function automatic logic [11:0] word_off();
	return 12'(4 * ($urandom % REGION));
endfunction

function automatic word_t random_inst();
	reg_addr_t rd, rs1, rs2;
	rd  = reg_addr_t'($urandom);	// x0 included on purpose
	rs1 = reg_addr_t'($urandom);
	rs2 = reg_addr_t'($urandom);
	case ($urandom % 10)
		0: return r_type(7'd0, F3_ADD_SUB, rd, rs1, rs2);
		1: return r_type(FUNCT7_SUB, F3_ADD_SUB, rd, rs1, rs2);
		2: return r_type(7'd0, F3_AND, rd, rs1, rs2);
		3: return r_type(7'd0, F3_OR, rd, rs1, rs2);
		4: return r_type(7'd0, F3_XOR, rd, rs1, rs2);
		5: return r_type(7'd0, F3_SLT, rd, rs1, rs2);
		6: return i_type(OP_IMM, F3_ADD_SUB, rd, rs1, 12'($urandom));
		7: return u_type(LUI, rd, 20'($urandom));
		8: return i_type(LOAD, F3_WORD, rd, 5'd0, word_off());	// Base x0 keeps it in region
		default: return s_type(rs2, 5'd0, word_off());
	endcase
endfunction

function automatic void build_random(input int len);
	prog.delete();
	for (int i = 0; i < len - 1; i++)
		prog.push_back(random_inst());
	prog.push_back(ecall());
endfunction

function automatic void clear_model_regs();
	for (int i = 0; i < 32; i++)
		ref_regs[i] = '0;
endfunction

function automatic word_t sext12(input logic [11:0] v);
	return {{20{v[11]}}, v};
endfunction

//////////////////////
// ISA reference model
//////////////////////
// Runs prog on ref_regs and exp_mem in place, up to the first ECALL
function automatic void run_model();
	word_t w, a, b, res, addr;
	logic [2:0] f3;
	reg_addr_t rd;
	logic wr;
	int pc;
	pc = 0;
	while (pc < prog.size()) begin
		w   = prog[pc];
		pc  = pc + 1;
		rd  = w[11:7];
		f3  = w[14:12];
		a   = ref_regs[w[19:15]];
		b   = ref_regs[w[24:20]];
		res = '0;
		wr  = 1'b0;
		case (w[6:0])
			OP: begin
				wr = 1'b1;
				case (f3)
					3'b000:  res = (w[31:25] == 7'b0100000) ? a - b : a + b;
					3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100:  res = a ^ b;
					3'b110:  res = a | b;
					3'b111:  res = a & b;
					default: wr = 1'b0;	// Shifts and SLTU do nothing
				endcase
			end
			OP_IMM: if (f3 == 3'b000) begin	// ADDI only
				res = a + sext12(w[31:20]);
				wr  = 1'b1;
			end
			LUI: begin
				res = {w[31:12], 12'b0};
				wr  = 1'b1;
			end
			LOAD: if (f3 == 3'b010) begin
				addr = a + sext12(w[31:20]);
				res  = exp_mem[addr[11:2]];
				wr   = 1'b1;
			end
			STORE: if (f3 == 3'b010) begin
				addr = a + sext12({w[31:25], w[11:7]});
				exp_mem[addr[11:2]] = b;
			end
			SYSTEM:  pc = prog.size();
			default: wr = 1'b0;
		endcase
		if (wr && rd != 5'd0)
			ref_regs[rd] = res;
	end
endfunction

`endif

// File: bench/core_tb.sv
`timescale 1ns/10ps

module core_tb;
	import core_pkg::*;
	import rv_isa_pkg::*;

	localparam int REGION = 64;	// Data words touched by the tests

	logic clk;
	logic reset;
	logic prog_write;
	logic [7:0] prog_addr;
	word_t prog_data;
	logic start;
	logic done;
	logic [3:0] con_write;
	dm_addr_t con_addr;
	word_t con_in;
	word_t con_out;

	word_t prog [$];		// Program under test
	word_t exp_mem [1024];		// Model data memory
	word_t ref_regs [32];		// Model registers kept across runs
	int cycles = 0;
	int cycle_limit = 100;		// Reset margin that grows per run
	int done_total = 0;

	`include "core_ref.svh"

	core #(
		.IM_DEPTH(256),
		.QUEUE_DEPTH(4)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.start(start),
		.done(done),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (done)
			done_total <= done_total + 1;	// Every halt pulse
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("test failed");
			$fatal(1);
		end
	end

	//////////////////////
	// Compare tasks
	//////////////////////
	task automatic check_word(input dm_addr_t addr, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] con_out word %h: expected %h, got %h", addr, exp, got);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_done_count(input int pulses, input int expected);
		if (pulses != expected) begin
			$display("Done pulsed %0d times where %0d were expected", pulses, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			prog_write <= 1'b1;
			prog_addr  <= 8'(i);
			prog_data  <= prog[i];
		end
		@(posedge clk);
		prog_write <= 1'b0;
	endtask

	// Fresh random data over the region
	task automatic preload_data();
		word_t val;
		for (int i = 0; i < REGION; i++) begin
			val = $urandom;
			exp_mem[i] = val;
			@(posedge clk);
			con_write <= 4'hf;
			con_addr  <= dm_addr_t'(i);
			con_in    <= val;
		end
		@(posedge clk);
		con_write <= 4'h0;
	endtask

	task automatic readback();
		for (int i = 0; i < REGION + 2; i++) begin
			@(posedge clk);
			if (i >= 2)	// Address from two edges back
				check_word(dm_addr_t'(i - 2), con_out, exp_mem[i - 2]);
			if (i < REGION)
				con_addr <= dm_addr_t'(i);
		end
	endtask

	task automatic run_program();
		int base;
		cycle_limit += 3 * prog.size() + REGION + 200;
		load_program();
		preload_data();
		@(posedge clk);
		start <= 1'b1;
		base = done_total;
		@(posedge clk);
		start <= 1'b0;
		while (done_total == base)
			@(posedge clk);
		run_model();
		readback();
		check_done_count(done_total - base, 1);	// Late repeats count too
	endtask

	initial begin
		int aborted;
		void'($urandom(98939));
		reset      <= 1'b1;
		prog_write <= 1'b0;
		prog_addr  <= '0;
		prog_data  <= '0;
		start      <= 1'b0;
		con_write  <= 4'h0;
		con_addr   <= '0;
		con_in     <= '0;
		clear_model_regs();
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// ALU ops and immediates with all results stored
		prog.delete();
		prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd123));
		prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'hfd3));	// -45
		prog.push_back(u_type(LUI, 5'd3, 20'habcde));
		prog.push_back(r_type(7'd0, F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
		prog.push_back(r_type(FUNCT7_SUB, F3_ADD_SUB, 5'd5, 5'd1, 5'd2));
		prog.push_back(r_type(7'd0, F3_AND, 5'd6, 5'd3, 5'd2));
		prog.push_back(r_type(7'd0, F3_OR, 5'd7, 5'd3, 5'd1));
		prog.push_back(r_type(7'd0, F3_XOR, 5'd8, 5'd2, 5'd3));
		prog.push_back(r_type(7'd0, F3_SLT, 5'd9, 5'd2, 5'd1));
		prog.push_back(r_type(7'd0, F3_SLT, 5'd10, 5'd1, 5'd2));
		prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 5'd11, 5'd3, 12'hfff));
		for (int r = 1; r < 12; r++)
			prog.push_back(s_type(reg_addr_t'(r), 5'd0, 12'(4 * r)));
		prog.push_back(ecall());
		run_program();

		// Loaded values used by the very next instruction
		prog.delete();
		prog.push_back(i_type(LOAD, F3_WORD, 5'd1, 5'd0, 12'd0));
		prog.push_back(r_type(7'd0, F3_ADD_SUB, 5'd2, 5'd1, 5'd1));
		prog.push_back(i_type(LOAD, F3_WORD, 5'd3, 5'd0, 12'd4));
		prog.push_back(r_type(FUNCT7_SUB, F3_ADD_SUB, 5'd4, 5'd3, 5'd1));
		prog.push_back(i_type(LOAD, F3_WORD, 5'd5, 5'd0, 12'd8));
		prog.push_back(r_type(7'd0, F3_XOR, 5'd6, 5'd5, 5'd3));
		prog.push_back(s_type(5'd2, 5'd0, 12'd64));
		prog.push_back(s_type(5'd4, 5'd0, 12'd68));
		prog.push_back(s_type(5'd6, 5'd0, 12'd72));
		prog.push_back(ecall());
		run_program();

		// Load burst that fills the queue and stalls fetch
		prog.delete();
		for (int r = 1; r <= 20; r++)
			prog.push_back(i_type(LOAD, F3_WORD, reg_addr_t'(r), 5'd0, 12'(4 * r)));
		for (int r = 1; r <= 20; r++)
			prog.push_back(s_type(reg_addr_t'(r), 5'd0, 12'(128 + 4 * r)));
		prog.push_back(ecall());
		run_program();

		// x0 writes and unsupported opcodes
		prog.delete();
		prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'd55));
		prog.push_back(r_type(7'd0, F3_ADD_SUB, 5'd0, 5'd1, 5'd1));
		prog.push_back(i_type(LOAD, F3_WORD, 5'd0, 5'd0, 12'd4));
		prog.push_back(u_type(7'b0010111, 5'd5, 20'h12345));	// AUIPC
		prog.push_back(u_type(7'b1101111, 5'd6, 20'h00010));	// JAL
		prog.push_back(r_type(7'd0, 3'b001, 5'd7, 5'd1, 5'd2));	// SLL
		prog.push_back(i_type(OP_IMM, 3'b010, 5'd8, 5'd1, 12'd1));	// SLTI
		prog.push_back(i_type(LOAD, 3'b000, 5'd9, 5'd0, 12'd0));	// LB
		for (int r = 0; r < 10; r++)
			prog.push_back(s_type(reg_addr_t'(r), 5'd0, 12'(160 + 4 * r)));
		prog.push_back(ecall());
		run_program();

		// Random programs back to back
		for (int n = 0; n < 4; n++) begin
			build_random(30 + int'($urandom % 31));
			run_program();
		end

		// Reset in the middle of a run
		build_random(40);
		cycle_limit += 3 * prog.size() + 200;
		load_program();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
		aborted = done_total;
		clear_model_regs();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (3 * prog.size()) @(posedge clk);
		check_done_count(done_total - aborted, 0);	// No halt without start
		run_program();

		$display("test passed");
		$finish;
	end

endmodule

// File: verilog/core.sv
`timescale 1ns/10ps

module core #(
	parameter int IM_DEPTH    = 256,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,

	// Program load while idle
	input logic prog_write,
	input logic [$clog2(IM_DEPTH)-1:0] prog_addr,
	input core_pkg::word_t prog_data,

	input logic start,	// One-cycle pulse
	output logic done,	// Pulses once at halt

	// Outside controller port
	input logic [3:0] con_write,
	input core_pkg::dm_addr_t con_addr,
	input core_pkg::word_t con_in,
	output core_pkg::word_t con_out
);

	inst_if q_in ();	// fetch to queue
	inst_if q_out ();	// queue to execute

	fetch_decode #(
		.IM_DEPTH(IM_DEPTH)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.q_in(q_in)
	);

	inst_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue0 (
		.clk(clk),
		.reset(reset),
		.q_in(q_in),
		.q_out(q_out)
	);

	execute exec0 (
		.clk(clk),
		.reset(reset),
		.q_out(q_out),
		.done(done),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

endmodule

// File: verilog/execute.sv
`timescale 1ns/10ps

module execute (
	input logic clk,
	input logic reset,
	inst_if.dst q_out,
	output logic done,

	// Outside controller port of data memory
	input logic [3:0] con_write,
	input core_pkg::dm_addr_t con_addr,
	input core_pkg::word_t con_in,
	output core_pkg::word_t con_out
);
	import core_pkg::*;

	typedef enum logic {EXEC, LOAD_WB} exec_state_e;

	exec_state_e state;
	dec_inst_t inst;
	word_t regs [32];
	word_t rs1_val, rs2_val;
	word_t op_b;
	word_t alu_out;
	word_t data_mem [1024];
	word_t dm_out;		// Sync read, valid in LOAD_WB
	dm_addr_t dm_addr;
	reg_addr_t load_rd;	// Destination held across the load
	logic accept;
	logic alu_wr, store_en, load_issue;

	assign inst   = q_out.inst;
	assign accept = q_out.valid && q_out.ready;

	// No intake during the load's second cycle
	assign q_out.ready = (state == EXEC);

	assign alu_wr     = accept && (inst.kind == K_ALU) && (inst.rd != '0);
	assign store_en   = accept && (inst.kind == K_STORE);
	assign load_issue = accept && (inst.kind == K_LOAD);

	////////////////////
	// Operands and ALU
	////////////////////
	assign rs1_val = regs[inst.rs1];	// x0 stays zero, never written
	assign rs2_val = regs[inst.rs2];
	assign op_b    = inst.use_imm ? inst.imm : rs2_val;

	always_comb begin
		case (inst.alu_op)
			OP_ADD:    alu_out = rs1_val + op_b;
			OP_SUB:    alu_out = rs1_val - op_b;
			OP_AND:    alu_out = rs1_val & op_b;
			OP_OR:     alu_out = rs1_val | op_b;
			OP_XOR:    alu_out = rs1_val ^ op_b;
			OP_SLT:    alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
			OP_PASS_B: alu_out = op_b;
			default:   alu_out = rs1_val + op_b;
		endcase
	end

	assign dm_addr = alu_out[11:2];	// Word address

	////////////////////
	// Data memory
	////////////////////
	always_ff @(posedge clk) begin
		if (store_en)
			data_mem[dm_addr] <= rs2_val;
		// Outside port comes last so it wins a same-word collision
		for (int b = 0; b < 4; b++) begin
			if (con_write[b])
				data_mem[con_addr][8*b +: 8] <= con_in[8*b +: 8];
		end
		dm_out  <= data_mem[dm_addr];
		con_out <= data_mem[con_addr];	// One cycle after sampling
	end

	always_ff @(posedge clk) begin
		if (load_issue)
			load_rd <= inst.rd;
	end

	////////////////////
	// Register file
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (state == LOAD_WB) begin
			if (load_rd != '0)
				regs[load_rd] <= dm_out;	// Load writeback
		end else if (alu_wr) begin
			regs[inst.rd] <= alu_out;
		end
	end

	// Load wait and halt pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EXEC;
			done  <= 1'b0;
		end else begin
			done <= accept && (inst.kind == K_HALT);	// Single cycle
			case (state)
				EXEC:    if (load_issue) state <= LOAD_WB;
				LOAD_WB: state <= EXEC;
				default: state <= EXEC;
			endcase
		end
	end

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/10ps

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	inst_if.dst q_in,
	inst_if.src q_out
);
	import core_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	dec_inst_t buffer [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;	// Occupancy
	logic push, pop;

	// Full queue refuses input even when popping
	assign q_in.ready  = (count != CNT_W'(QUEUE_DEPTH));
	assign q_out.valid = (count != '0);
	assign q_out.inst  = buffer[rd_ptr];	// Head visible the cycle after write

	assign push = q_in.valid && q_in.ready;
	assign pop  = q_out.valid && q_out.ready;

	always_ff @(posedge clk) begin
		if (push)
			buffer[wr_ptr] <= q_in.inst;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)	// Wrap also for non power of two depths
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

// File: verilog/fetch_decode.sv
`timescale 1ns/10ps

module fetch_decode #(
	parameter int IM_DEPTH = 256
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic prog_write,
	input logic [$clog2(IM_DEPTH)-1:0] prog_addr,
	input core_pkg::word_t prog_data,
	inst_if.src q_in
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	localparam int PC_W = $clog2(IM_DEPTH);

	typedef enum logic {IDLE, RUN} fetch_state_e;

	fetch_state_e state;
	logic [PC_W-1:0] pc;		// Word index into program memory
	word_t prog_mem [IM_DEPTH];
	word_t raw;			// Current instruction word
	opcode_e opcode;
	funct3_e funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_u;
	dec_inst_t dec;
	logic xfer;			// Handoff to queue this cycle

	////////////////////
	// Program memory
	////////////////////
	always_ff @(posedge clk) begin
		if (prog_write)
			prog_mem[prog_addr] <= prog_data;	// Loaded while idle
	end

	assign raw    = prog_mem[pc];	// Async read, zero fetch latency
	assign opcode = opcode_e'(raw[OPC_LSB +: 7]);
	assign funct3 = funct3_e'(raw[F3_LSB +: 3]);
	assign funct7 = raw[F7_LSB +: 7];

	// Immediate formats
	assign imm_i = {{20{raw[31]}}, raw[31:20]};
	assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
	assign imm_u = {raw[31:12], 12'b0};

	////////////////////
	// Decoder
	////////////////////
	always_comb begin
		dec         = '0;
		dec.kind    = K_NOP;	// Anything unknown falls through as nop
		dec.alu_op  = OP_ADD;
		dec.rs1     = raw[RS1_LSB +: 5];
		dec.rs2     = raw[RS2_LSB +: 5];
		dec.rd      = raw[RD_LSB +: 5];
		case (opcode)
			OP: begin
				dec.kind = K_ALU;
				case (funct3)
					F3_ADD_SUB: dec.alu_op = (funct7 == FUNCT7_SUB) ? OP_SUB : OP_ADD;
					F3_SLT:     dec.alu_op = OP_SLT;
					F3_XOR:     dec.alu_op = OP_XOR;
					F3_OR:      dec.alu_op = OP_OR;
					F3_AND:     dec.alu_op = OP_AND;
					default:    dec.kind   = K_NOP;	// Shifts, SLTU not kept
				endcase
			end
			OP_IMM: if (funct3 == F3_ADD_SUB) begin	// ADDI only
				dec.kind    = K_ALU;
				dec.use_imm = 1'b1;
				dec.imm     = imm_i;
			end
			LUI: begin
				dec.kind    = K_ALU;
				dec.alu_op  = OP_PASS_B;
				dec.use_imm = 1'b1;
				dec.imm     = imm_u;
			end
			LOAD: if (funct3 == F3_WORD) begin
				dec.kind    = K_LOAD;
				dec.use_imm = 1'b1;	// Address = rs1 + imm
				dec.imm     = imm_i;
			end
			STORE: if (funct3 == F3_WORD) begin
				dec.kind    = K_STORE;
				dec.use_imm = 1'b1;
				dec.imm     = imm_s;
			end
			SYSTEM:  dec.kind = K_HALT;
			default: dec.kind = K_NOP;
		endcase
	end

	////////////////////
	// PC and run control
	////////////////////
	assign q_in.valid = (state == RUN);
	assign q_in.inst  = dec;
	assign xfer       = q_in.valid && q_in.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pc    <= '0;
		end else begin
			case (state)
				IDLE: if (start) begin	// Start ignored while running
					pc    <= '0;
					state <= RUN;
				end
				RUN: if (xfer) begin	// Hold PC under back-pressure
					pc <= pc + 1'b1;
					if (dec.kind == K_HALT)
						state <= IDLE;	// Stop after handing off halt
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: verilog/inst_if.sv
`timescale 1ns/10ps

// Decoded instruction handoff with valid/ready
interface inst_if;
	import core_pkg::*;

	logic      valid;
	logic      ready;
	dec_inst_t inst;

	// Source holds valid and inst until the transfer
	modport src (output valid, output inst, input ready);

	modport dst (input valid, input inst, output ready);

endinterface

// File: verilog/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;		// Register and memory data
	typedef logic [4:0]  reg_addr_t;	// Register index
	typedef logic [9:0]  dm_addr_t;		// Data memory word address

	// ALU operations
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_PASS_B	// LUI passes the immediate
	} alu_op_e;

	// What execute does with an item
	typedef enum logic [2:0] {
		K_NOP,
		K_ALU,
		K_LOAD,
		K_STORE,
		K_HALT
	} inst_kind_e;

	// Decoded instruction record
	typedef struct packed {
		inst_kind_e kind;
		alu_op_e    alu_op;
		logic       use_imm;	// Operand B from imm
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rd;
		word_t      imm;	// Already extended or shifted
	} dec_inst_t;

endpackage

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	////////////////////
	// Major opcodes
	////////////////////
	typedef enum logic [6:0] {
		OP     = 7'b0110011,	// R-type ALU
		OP_IMM = 7'b0010011,	// I-type ALU
		LUI    = 7'b0110111,	// Upper immediate
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		SYSTEM = 7'b1110011	// ECALL acts as halt
	} opcode_e;

	////////////////////
	// funct3 codes
	////////////////////
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,	// ADD, SUB, ADDI
		F3_SLT     = 3'b010,
		F3_XOR     = 3'b100,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	// Word access shares its code with SLT
	localparam funct3_e F3_WORD = F3_SLT;

	// funct7 that turns ADD into SUB
	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

	////////////////////
	// Field positions
	////////////////////
	localparam int OPC_LSB = 0;	// opcode [6:0]
	localparam int RD_LSB  = 7;	// rd [11:7]
	localparam int F3_LSB  = 12;	// funct3 [14:12]
	localparam int RS1_LSB = 15;	// rs1 [19:15]
	localparam int RS2_LSB = 20;	// rs2 [24:20]
	localparam int F7_LSB  = 25;	// funct7 [31:25]

endpackage
